// File: keypadPkg.sv
// ----------------------------------------------------------
// shared types and constants for the 4x4 keypad terminal
// segment bytes are active low, bit 7 is dp and bits 6..0 are g..a
// the hex font assumes a common-anode display
// ----------------------------------------------------------
`default_nettype none

package keypadPkg;

    localparam int NUM_COLS      = 4;     // keypad columns, driven low one at a time
    localparam int NUM_ROWS      = 4;     // keypad rows, sensed active low
    localparam int FRAME_LEN     = 8;     // states per scan frame
    localparam int PUBLISH_STATE = 4;     // keyCode updates at the end of this state
    localparam int NUM_DIGITS    = 4;     // seven-segment digits
    localparam int ENTRY_W       = 16;    // four hex digits of entry

    // one 5-bit word, read as a code or as valid + digit
    typedef union packed {
        logic [4:0] raw;                  // zero means no key
        struct packed {
            logic       valid;
            logic [3:0] digit;            // hex value 0..F
        } fields;
    } keyCode_u;

    typedef struct packed {
        logic [NUM_DIGITS-1:0] anode;     // one-hot, active low
        logic [7:0]            segment;   // {dp, g..a}, active low
    } segOut_t;

    // standard hex font, returned active low with dp off
    function automatic logic [7:0] segmentOf(input logic [3:0] digit);
        logic [6:0] lit;                  // active high g..a
        case (digit)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;            // lower case b
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;            // lower case d
            4'hE: lit = 7'h79;
            default: lit = 7'h71;         // F
        endcase
        return {1'b1, ~lit};
    endfunction

endpackage

`default_nettype wire

// File: keypadScanner.sv
// ----------------------------------------------------------
// column-scan keypad controller, one key code per 8-state frame
// rows need external pull-ups, one key at a time is assumed
// two rows low in one column match nothing, last column wins
// no debounce beyond the frame-rate sampling
// ----------------------------------------------------------
`default_nettype none

module keypadScanner (
    input  logic                           CLK_96Hz,
    input  logic                           reset,
    input  logic [keypadPkg::NUM_ROWS-1:0] rows,     // active low
    output logic [keypadPkg::NUM_COLS-1:0] cols,     // low drives the column
    output keypadPkg::keyCode_u            keyCode
);
    import keypadPkg::*;

    logic [$clog2(FRAME_LEN)-1:0] state;          // frame position 0..7
    logic [$clog2(FRAME_LEN)-1:0] nextState;
    logic [1:0]                   rowIdx;         // 0 is row 1
    logic                         rowHit;         // exactly one row low
    keyCode_u                     localCode;      // code gathered this frame
    keyCode_u                     tableCode;      // table entry for state and row

    // column pattern that is visible during state s
    function automatic logic [NUM_COLS-1:0] colDrive(
        input logic [$clog2(FRAME_LEN)-1:0] s
    );
        logic [NUM_COLS-1:0] pattern;
        pattern = '1;                             // idle states leave all high
        if (s < NUM_COLS)
        begin
            pattern[NUM_COLS-1-s] = 1'b0;         // state 0 is column 1 (msb)
        end
        return pattern;
    endfunction

    // keypad legend by column and row
    function automatic logic [3:0] keyDigit(input logic [1:0] col, input logic [1:0] row);
        logic [3:0] digit;
        case ({col, row})
            4'b00_00: digit = 4'hA;
            4'b00_01: digit = 4'hB;
            4'b00_10: digit = 4'hC;
            4'b00_11: digit = 4'hD;
            4'b01_00: digit = 4'h1;
            4'b01_01: digit = 4'h4;
            4'b01_10: digit = 4'h7;
            4'b01_11: digit = 4'h0;
            4'b10_00: digit = 4'h2;
            4'b10_01: digit = 4'h5;
            4'b10_10: digit = 4'h8;
            4'b10_11: digit = 4'hF;
            4'b11_00: digit = 4'h3;
            4'b11_01: digit = 4'h6;
            4'b11_10: digit = 4'h9;
            default:  digit = 4'hE;
        endcase
        return digit;
    endfunction

    assign nextState = state + 1'b1;              // wraps at FRAME_LEN

    always_comb
    begin
        rowHit = 1'b1;
        rowIdx = 2'd0;
        case (rows)
            4'b0111: rowIdx = 2'd0;               // row 1
            4'b1011: rowIdx = 2'd1;
            4'b1101: rowIdx = 2'd2;
            4'b1110: rowIdx = 2'd3;               // row 4
            default: rowHit = 1'b0;               // none, or several rows low
        endcase
    end

    always_comb
    begin
        tableCode.fields.valid = 1'b1;
        tableCode.fields.digit = keyDigit(state[1:0], rowIdx);
    end

    always_ff @(posedge CLK_96Hz)
    begin
        if (reset)
        begin
            state     <= '0;
            cols      <= '1;                      // nothing driven
            localCode <= '0;
            keyCode   <= '0;
        end
        else
        begin
            state <= nextState;
            cols  <= colDrive(nextState);         // registered, ready for next state
            if (state < NUM_COLS)
            begin
                if (rowHit)
                begin
                    localCode <= tableCode;       // sample at end of column state
                end
            end
            else if (state == PUBLISH_STATE)
            begin
                keyCode <= localCode;             // one update per frame
            end
            else
            begin
                localCode.raw <= '0;              // released key reads as zero next frame
            end
        end
    end

endmodule

`default_nettype wire

// File: keyEntry.sv
// ----------------------------------------------------------
// hex digit entry from scanned key codes
// one digit per press, a held key enters once
// the newest digit sits in the low nibble, the oldest drops out
// no clear or backspace
// ----------------------------------------------------------
`default_nettype none

module keyEntry (
    input  logic                          CLK_96Hz,
    input  logic                          reset,
    input  keypadPkg::keyCode_u           keyCode,      // level, changes once per frame
    output logic [keypadPkg::ENTRY_W-1:0] entryValue,
    output logic                          keyStrobe     // one cycle per press
);
    import keypadPkg::*;

    logic prevValid;                              // valid bit one cycle back
    logic pressEdge;                              // valid just rose

    // keyCode holds for a whole frame, so a held key keeps valid high
    // and gives no second edge
    assign pressEdge = keyCode.fields.valid & ~prevValid;

    always_ff @(posedge CLK_96Hz)
    begin
        if (reset)
        begin
            prevValid <= 1'b0;
            keyStrobe <= 1'b0;
        end
        else
        begin
            prevValid <= keyCode.fields.valid;
            keyStrobe <= pressEdge;               // lines up with the shift below
        end
    end

    // entry register, shifted left by one hex digit per press
    always_ff @(posedge CLK_96Hz)
    begin
        if (reset)
        begin
            entryValue <= '0;                     // display starts at 0000
        end
        else if (pressEdge)
        begin
            entryValue <= {entryValue[ENTRY_W-5:0], keyCode.fields.digit};
        end
    end

endmodule

`default_nettype wire

// File: segmentDisplay.sv
// ----------------------------------------------------------
// multiplexed seven-segment driver for the entry value
// one digit per clock, so each digit refreshes at about 24 Hz
// anodes and segments are active low, common-anode parts assumed
// shown nibble lags entryValue by one cycle
// ----------------------------------------------------------
`default_nettype none

module segmentDisplay (
    input  logic                          CLK_96Hz,
    input  logic                          reset,
    input  logic [keypadPkg::ENTRY_W-1:0] entryValue,
    output keypadPkg::segOut_t            display
);
    import keypadPkg::*;

    logic [$clog2(NUM_DIGITS)-1:0] digitSel;      // digit being driven next
    logic [3:0]                    nibble;        // hex value of that digit

    assign nibble = entryValue[digitSel*4 +: 4];  // digit 0 is the low nibble

    // digit counter and anode select
    always_ff @(posedge CLK_96Hz)
    begin
        if (reset)
        begin
            digitSel      <= '0;
            display.anode <= '1;                  // blank for first cycle
        end
        else
        begin
            digitSel      <= digitSel + 1'b1;     // 0,1,2,3 then wraps
            display.anode <= ~(NUM_DIGITS'(1) << digitSel);
        end
    end

    // segment pattern follows the anode in the same cycle
    always_ff @(posedge CLK_96Hz)
    begin
        display.segment <= segmentOf(nibble);     // hidden while anodes are off
    end

endmodule

`default_nettype wire

// File: keypadTerminal.sv
// ----------------------------------------------------------
// hex keypad entry terminal top level
// whole design runs on the slow scan clock CLK_96Hz
// rows need pull-ups, outputs are plain levels and strobes
// ----------------------------------------------------------
`default_nettype none

module keypadTerminal (
    input  logic                           CLK_96Hz,
    input  logic                           reset,
    input  logic [keypadPkg::NUM_ROWS-1:0] rows,        // active low
    output logic [keypadPkg::NUM_COLS-1:0] cols,        // active low
    output keypadPkg::keyCode_u            keyCode,
    output logic [keypadPkg::ENTRY_W-1:0]  entryValue,
    output logic                           keyStrobe,
    output keypadPkg::segOut_t             display
);

    // matrix scan, one code per frame
    keypadScanner scanner (
        .CLK_96Hz (CLK_96Hz),
        .reset    (reset),
        .rows     (rows),
        .cols     (cols),
        .keyCode  (keyCode)
    );

    // press detect and digit shift
    keyEntry entry (
        .CLK_96Hz   (CLK_96Hz),
        .reset      (reset),
        .keyCode    (keyCode),
        .entryValue (entryValue),
        .keyStrobe  (keyStrobe)
    );

    // four-digit mux
    segmentDisplay segDisplay (
        .CLK_96Hz   (CLK_96Hz),
        .reset      (reset),
        .entryValue (entryValue),
        .display    (display)
    );

endmodule

`default_nettype wire

// File: keypadTerminal_checker.sv
// ----------------------------------------------------------
// concurrent assertions on the terminal outputs, bound in the testbench
// keyCode update rule relies on 1110 being unique to scan state 3
// all checks are off while reset is high
// ----------------------------------------------------------
`default_nettype none

module keypadTerminal_checker (
    input logic                             CLK_96Hz,
    input logic                             reset,
    input logic [keypadPkg::NUM_COLS-1:0]   cols,
    input keypadPkg::keyCode_u              keyCode,
    input logic [keypadPkg::NUM_DIGITS-1:0] anode
);
    timeunit 1ns;
    timeprecision 1ps;
    import keypadPkg::*;

    int failCount = 0;                            // read by the testbench at the end

    // never two keypad columns driven at once
    colsOneLow: assert property (@(posedge CLK_96Hz) disable iff (reset)
        $countones(~cols) <= 1)
    else
    begin
        failCount++;
        $error("more than one keypad column driven low: %b", cols);
    end

    // one digit lit, or all blank
    anodeOneHot: assert property (@(posedge CLK_96Hz) disable iff (reset)
        $onehot0(~anode))
    else
    begin
        failCount++;
        $error("more than one display anode active: %b", anode);
    end

    // keyCode moves only right after the publish state
    keyCodeAtPublish: assert property (@(posedge CLK_96Hz) disable iff (reset)
        $changed(keyCode.raw) |-> $past(cols, 2) == 4'b1110)
    else
    begin
        failCount++;
        $error("keyCode changed outside the publish state: %h", keyCode.raw);
    end

endmodule

`default_nettype wire

// File: keypadMonitor.sv
// ----------------------------------------------------------
// reference model and comparator for the keypad terminal
// model advances on every rising edge from the press stimulus
// segments are only compared while a digit is lit
// ----------------------------------------------------------
`default_nettype none

module keypadMonitor (
    input  logic                           CLK_96Hz,
    input  logic                           reset,
    input  logic [keypadPkg::NUM_COLS-1:0] cols,
    input  keypadPkg::keyCode_u            keyCode,
    input  logic [keypadPkg::ENTRY_W-1:0]  entryValue,
    input  logic                           keyStrobe,
    input  keypadPkg::segOut_t             display,
    input  logic                           press,       // key held this cycle
    input  logic [1:0]                     pressRow,    // 0 is row 1
    input  logic [1:0]                     pressCol,    // 0 is column 1
    output int                             errorCount,
    output int                             strobeCount
);
    timeunit 1ns;
    timeprecision 1ps;
    import keypadPkg::*;

    // keypad legend, column 1 first, row 1 first inside each column
    localparam logic [63:0]  KEY_LEGEND = 64'hABCD_1470_258F_369E;
    // hex font g..a active high, digit d at bits d*8
    localparam logic [127:0] HEX_FONT   = 128'h71_79_5E_39_7C_77_6F_7F_07_7D_6D_66_4F_5B_06_3F;

    int                    mState;                // scan state of the cycle in progress
    logic [NUM_COLS-1:0]   mCols;
    logic [4:0]            mLocal;
    logic [4:0]            mKey;                  // {valid, digit}
    logic                  mPrevValid;
    logic                  mStrobe;
    logic [ENTRY_W-1:0]    mEntry;
    int                    mSel;                  // digit to be lit next
    logic [NUM_DIGITS-1:0] mAnode;
    logic [7:0]            mSeg;
    logic                  started;               // a reset edge has been seen
    logic                  hit;
    logic                  pressEdge;

    function automatic logic [3:0] legendDigit(input int col, input int row);
        return KEY_LEGEND[63 - (col * 4 + row) * 4 -: 4];
    endfunction

    function automatic logic [NUM_COLS-1:0] colPattern(input int s);
        return (s < NUM_COLS) ? ~(4'b1000 >> s) : 4'b1111;
    endfunction

    task automatic compareValue(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
        if (actual !== expected)
        begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    initial
    begin
        errorCount  = 0;
        strobeCount = 0;
        started     = 1'b0;
    end

    always @(posedge CLK_96Hz)
    begin
        if (reset)
        begin
            mState     = 0;
            mCols      = '1;                      // nothing driven yet
            mLocal     = '0;
            mKey       = '0;
            mPrevValid = 1'b0;
            mStrobe    = 1'b0;
            mEntry     = '0;
            mSel       = 0;
            mAnode     = '1;                      // blank first cycle
            started    = 1'b1;
        end
        else if (started)
        begin
            compareValue("cols", 16'(mCols), 16'(cols));
            compareValue("keyCode", 16'(mKey), 16'(keyCode.raw));
            compareValue("keyStrobe", 16'(mStrobe), 16'(keyStrobe));
            compareValue("entryValue", mEntry, entryValue);
            compareValue("display.anode", 16'(mAnode), 16'(display.anode));
            if (mAnode != '1)
                compareValue("display.segment", 16'(mSeg), 16'(display.segment));
            if (keyStrobe === 1'b1)
                strobeCount++;

            hit       = press && (mCols[NUM_COLS - 1 - pressCol] == 1'b0);
            pressEdge = mKey[4] && !mPrevValid;
            // display shows the entry of the cycle just ended
            mAnode = ~(4'b0001 << mSel);
            mSeg   = {1'b1, ~HEX_FONT[mEntry[mSel * 4 +: 4] * 8 +: 7]};
            mSel   = (mSel + 1) % NUM_DIGITS;
            // entry shift on a fresh valid code
            mStrobe    = pressEdge;
            if (pressEdge)
                mEntry = {mEntry[ENTRY_W-5:0], mKey[3:0]};
            mPrevValid = mKey[4];
            // scan frame
            if (mState < NUM_COLS)
            begin
                if (hit)
                    mLocal = {1'b1, legendDigit(pressCol, pressRow)};
            end
            else if (mState == PUBLISH_STATE)
                mKey = mLocal;
            else
                mLocal = '0;                      // idle states forget the key
            mState = (mState + 1) % FRAME_LEN;
            mCols  = colPattern(mState);
        end
    end

endmodule

`default_nettype wire

// File: keypadTerminal_tb.sv
// ----------------------------------------------------------
// testbench for the keypad terminal, 40 random key presses
// keypad matrix is modelled as one key at a time, no bounce
// hold of 16..47 cycles and release of 16..31 cycles per press
// ----------------------------------------------------------
`default_nettype none

module keypadTerminal_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import keypadPkg::*;

    localparam int          NUM_PRESSES  = 40;
    localparam int          RESET_CYCLES = 10;
    localparam int          MAX_CYCLES   = 4000;  // 10 + 40 * 80 plus margin
    localparam logic [31:0] LFSR_SEED    = 32'he370_f6d7;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

    logic                  CLK_96Hz = 1'b0;
    logic                  reset;
    logic [NUM_ROWS-1:0]   rows;
    logic [NUM_COLS-1:0]   cols;
    keyCode_u              keyCode;
    logic [ENTRY_W-1:0]    entryValue;
    logic                  keyStrobe;
    segOut_t               display;

    logic                  press;
    logic [1:0]            pressRow;
    logic [1:0]            pressCol;
    logic [31:0]           lfsr;
    logic [7:0]            rowBits;
    logic [7:0]            colBits;
    logic [7:0]            holdBits;
    logic [7:0]            releaseBits;
    int                    errorCount;
    int                    strobeCount;
    int                    otherErrors = 0;
    int                    cycleCount  = 0;

    always #5 CLK_96Hz = ~CLK_96Hz;               // 10 ns period

    // pressed key pulls its row low while its column is driven
    assign rows = (press && cols[NUM_COLS - 1 - pressCol] == 1'b0)
                ? ~(4'b1000 >> pressRow) : 4'b1111;

    keypadTerminal dut (
        .CLK_96Hz   (CLK_96Hz),
        .reset      (reset),
        .rows       (rows),
        .cols       (cols),
        .keyCode    (keyCode),
        .entryValue (entryValue),
        .keyStrobe  (keyStrobe),
        .display    (display)
    );

    keypadMonitor monitor (
        .CLK_96Hz    (CLK_96Hz),
        .reset       (reset),
        .cols        (cols),
        .keyCode     (keyCode),
        .entryValue  (entryValue),
        .keyStrobe   (keyStrobe),
        .display     (display),
        .press       (press),
        .pressRow    (pressRow),
        .pressCol    (pressCol),
        .errorCount  (errorCount),
        .strobeCount (strobeCount)
    );

    bind keypadTerminal keypadTerminal_checker protocolCheck (
        .CLK_96Hz (CLK_96Hz),
        .reset    (reset),
        .cols     (cols),
        .keyCode  (keyCode),
        .anode    (display.anode)
    );

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit, msb taken first
    task automatic randomBits(input int count, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            value = {value[6:0], lfsr[0]};
            lfsr  = lfsrStep(lfsr);
        end
    endtask

    task automatic printCounts();
        $display("errors: %0d value mismatches, %0d assertion failures, %0d other",
                 errorCount, dut.protocolCheck.failCount, otherErrors);
    endtask

    initial
    begin
        reset    = 1'b1;
        press    = 1'b0;
        pressRow = 2'd0;
        pressCol = 2'd0;
        lfsr     = LFSR_SEED;
        repeat (RESET_CYCLES) @(posedge CLK_96Hz);
        reset <= 1'b0;
        for (int n = 0; n < NUM_PRESSES; n++)
        begin
            randomBits(2, rowBits);
            randomBits(2, colBits);
            randomBits(5, holdBits);
            randomBits(4, releaseBits);
            press    <= 1'b1;
            pressRow <= rowBits[1:0];
            pressCol <= colBits[1:0];
            repeat (16 + holdBits) @(posedge CLK_96Hz);      // 16..47 cycles held
            press <= 1'b0;
            repeat (16 + releaseBits) @(posedge CLK_96Hz);   // 16..31 cycles up
        end
        @(negedge CLK_96Hz);                      // let the last compare settle
        if (strobeCount != NUM_PRESSES)
        begin
            otherErrors++;
            $display("wrong number of key strobes: %0d seen for %0d presses",
                     strobeCount, NUM_PRESSES);
        end
        printCounts();
        if (errorCount + otherErrors + dut.protocolCheck.failCount == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // run limit
    always @(posedge CLK_96Hz)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == MAX_CYCLES)
        begin
            otherErrors++;
            $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
            printCounts();
            $display("RESULT: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: keypadTerminal.f
keypadPkg.sv
keypadScanner.sv
keyEntry.sv
segmentDisplay.sv
keypadTerminal.sv
keypadTerminal_checker.sv
keypadMonitor.sv
keypadTerminal_tb.sv
